// ==== rtl/bev_macros.svh ====
`ifndef BEV_MACROS_SVH
`define BEV_MACROS_SVH

// ingredient amount and stock ceiling
`define BEV_AMT_W    12
`define BEV_AMT_MAX  4095

// cup volumes
`define BEV_CUP_S    480
`define BEV_CUP_M    720
`define BEV_CUP_L    960

// box records in external memory, eight bytes per box
`define BEV_BOX_W    8
`define BEV_ADDR_W   17
`define BEV_MEM_BASE 65536
`define BEV_REC_W    64

`endif

// ==== rtl/bev_pkg.sv ====
`include "bev_macros.svh"

package bev_pkg;

    typedef enum logic [1:0] {MAKE_DRINK, SUPPLY, CHECK_DATE} action_e;

    typedef enum logic [2:0] {
        BLACK_TEA, MILK_TEA, EXTRA_MILK_TEA, GREEN_TEA, GREEN_MILK_TEA,
        PINEAPPLE_JUICE, SUPER_PINEAPPLE_TEA, SUPER_PINEAPPLE_MILK_TEA
    } drink_e;

    typedef enum logic [1:0] {L, M, S} size_e;

    typedef enum logic [1:0] {NO_ERR, NO_EXP, NO_ING, ING_OF} err_e;

    typedef enum logic [3:0] {
        IDLE, GET_TYPE, GET_SIZE, GET_DATE, GET_BOX,
        GET_SUPPLY, READ_REQ, READ_WAIT, EVAL, REPORT
    } ctrl_state_e;

    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    // memory layout of one box
    typedef struct packed {
        logic [`BEV_AMT_W-1:0] black_tea;
        logic [`BEV_AMT_W-1:0] green_tea;
        logic [7:0]            month;
        logic [`BEV_AMT_W-1:0] milk;
        logic [`BEV_AMT_W-1:0] pineapple;
        logic [7:0]            day;
    } box_rec_t;

    // recipe shares in quarters of the cup
    typedef struct packed {
        logic [2:0] black_tea;
        logic [2:0] green_tea;
        logic [2:0] milk;
        logic [2:0] pineapple;
    } recipe_t;

    function automatic recipe_t recipe_q(drink_e drink);
        recipe_t q;
        case (drink)
            BLACK_TEA:           q = '{3'd4, 3'd0, 3'd0, 3'd0};
            MILK_TEA:            q = '{3'd3, 3'd0, 3'd1, 3'd0};
            EXTRA_MILK_TEA:      q = '{3'd2, 3'd0, 3'd2, 3'd0};
            GREEN_TEA:           q = '{3'd0, 3'd4, 3'd0, 3'd0};
            GREEN_MILK_TEA:      q = '{3'd0, 3'd2, 3'd2, 3'd0};
            PINEAPPLE_JUICE:     q = '{3'd0, 3'd0, 3'd0, 3'd4};
            SUPER_PINEAPPLE_TEA: q = '{3'd2, 3'd0, 3'd0, 3'd2};
            // super pineapple milk tea
            default:             q = '{3'd2, 3'd0, 3'd1, 3'd1};
        endcase
        return q;
    endfunction

endpackage

// ==== rtl/bev_if.sv ====
`timescale 1ns/1ps
`include "bev_macros.svh"

// one order as captured from the input bus
interface bev_order_if;
    bev_pkg::action_e       action;
    bev_pkg::drink_e        drink;
    bev_pkg::size_e         size;
    bev_pkg::date_t         date;
    logic [`BEV_BOX_W-1:0]  box_no;
    logic [`BEV_AMT_W-1:0]  sup_black_tea;
    logic [`BEV_AMT_W-1:0]  sup_green_tea;
    logic [`BEV_AMT_W-1:0]  sup_milk;
    logic [`BEV_AMT_W-1:0]  sup_pineapple;

    modport source (
        output action, drink, size, date, box_no,
        output sup_black_tea, sup_green_tea, sup_milk, sup_pineapple
    );
    modport consumer (
        input action, drink, size, date, box_no,
        input sup_black_tea, sup_green_tea, sup_milk, sup_pineapple
    );
endinterface

// record reads and posted write-backs towards the bridge
interface bev_mem_if;
    logic                   rd_req;
    logic                   rd_done;
    logic [`BEV_REC_W-1:0]  rd_data;
    logic                   wr_req;
    logic [`BEV_REC_W-1:0]  wr_data;
    logic                   wr_busy;

    modport ctrl   (output rd_req, input rd_done, wr_busy);
    modport recipe (output wr_req, wr_data, input rd_done, rd_data);
    modport port   (input rd_req, wr_req, wr_data, output rd_done, rd_data, wr_busy);
endinterface

// ==== rtl/bev_ctrl.sv ====
`timescale 1ns/1ps

module bev_ctrl (
    input  logic                 clk,
    input  logic                 inf,
    input  logic                 sel_action_valid,
    input  logic                 type_valid,
    input  logic                 size_valid,
    input  logic                 date_valid,
    input  logic                 box_no_valid,
    input  logic                 box_sup_valid,
    input  bev_pkg::action_e     action,
    input  bev_pkg::err_e        err,
    bev_mem_if.ctrl              mem,
    output bev_pkg::ctrl_state_e state,
    output logic [1:0]           sup_beat,
    output logic                 out_valid,
    output logic                 complete,
    output bev_pkg::err_e        err_msg
);
    bev_pkg::ctrl_state_e next_state;

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            state <= bev_pkg::IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            bev_pkg::IDLE:
            begin
                if (sel_action_valid)
                begin
                    if (action == bev_pkg::MAKE_DRINK)
                        next_state = bev_pkg::GET_TYPE;
                    else if (action == bev_pkg::SUPPLY || action == bev_pkg::CHECK_DATE)
                        next_state = bev_pkg::GET_DATE;
                end
            end
            bev_pkg::GET_TYPE:   if (type_valid) next_state = bev_pkg::GET_SIZE;
            bev_pkg::GET_SIZE:   if (size_valid) next_state = bev_pkg::GET_DATE;
            bev_pkg::GET_DATE:   if (date_valid) next_state = bev_pkg::GET_BOX;
            bev_pkg::GET_BOX:
            begin
                if (box_no_valid)
                    next_state = (action == bev_pkg::SUPPLY) ? bev_pkg::GET_SUPPLY
                                                             : bev_pkg::READ_REQ;
            end
            bev_pkg::GET_SUPPLY:
            begin
                if (box_sup_valid && sup_beat == 2'd3)
                    next_state = bev_pkg::READ_REQ;
            end
            // hold here while a write-back is still in flight
            bev_pkg::READ_REQ:   if (!mem.wr_busy) next_state = bev_pkg::READ_WAIT;
            bev_pkg::READ_WAIT:  if (mem.rd_done) next_state = bev_pkg::EVAL;
            bev_pkg::EVAL:       next_state = bev_pkg::REPORT;
            default:             next_state = bev_pkg::IDLE;
        endcase
    end

    assign mem.rd_req = (state == bev_pkg::READ_REQ) && !mem.wr_busy;

    // supply beat counter wraps back to zero after the fourth
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
            sup_beat <= 2'd0;
        else if (state == bev_pkg::GET_SUPPLY && box_sup_valid)
            sup_beat <= sup_beat + 2'd1;
        else if (state == bev_pkg::IDLE)
            sup_beat <= 2'd0;
    end

    // results valid for the single REPORT cycle
    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            out_valid <= 1'b0;
            complete  <= 1'b0;
            err_msg   <= bev_pkg::NO_ERR;
        end
        else if (state == bev_pkg::EVAL)
        begin
            out_valid <= 1'b1;
            complete  <= (err == bev_pkg::NO_ERR);
            err_msg   <= err;
        end
        else
        begin
            out_valid <= 1'b0;
            complete  <= 1'b0;
            err_msg   <= bev_pkg::NO_ERR;
        end
    end

    a_out_valid_single: assert property (@(posedge clk) disable iff (!inf)
        out_valid |=> !out_valid);

    // no write-back may be in flight while the read is outstanding
    a_no_read_over_write: assert property (@(posedge clk) disable iff (!inf)
        (state == bev_pkg::READ_WAIT) |-> !mem.wr_busy);

endmodule

// ==== rtl/bev_order_regs.sv ====
`timescale 1ns/1ps
`include "bev_macros.svh"

module bev_order_regs (
    input  logic                  clk,
    input  logic [`BEV_AMT_W-1:0] in_data,
    input  logic                  sel_action_valid,
    input  logic                  type_valid,
    input  logic                  size_valid,
    input  logic                  date_valid,
    input  logic                  box_no_valid,
    input  logic                  box_sup_valid,
    input  bev_pkg::ctrl_state_e  state,
    input  logic [1:0]            sup_beat,
    bev_order_if.source           order
);
    bev_pkg::action_e action_q;
    logic             take_action;

    assign take_action = (state == bev_pkg::IDLE) && sel_action_valid;

    // the FSM branches on the action in the strobe cycle itself
    assign order.action = take_action ? bev_pkg::action_e'(in_data[1:0]) : action_q;

    always_ff @(posedge clk)
    begin
        if (take_action)
            action_q <= bev_pkg::action_e'(in_data[1:0]);
        if (type_valid && state == bev_pkg::GET_TYPE)
            order.drink <= bev_pkg::drink_e'(in_data[2:0]);
        if (size_valid && state == bev_pkg::GET_SIZE)
            order.size <= bev_pkg::size_e'(in_data[1:0]);
        if (date_valid && state == bev_pkg::GET_DATE)
            order.date <= bev_pkg::date_t'(in_data[8:0]);
        if (box_no_valid && state == bev_pkg::GET_BOX)
            order.box_no <= in_data[`BEV_BOX_W-1:0];
        if (box_sup_valid && state == bev_pkg::GET_SUPPLY)
        begin
            case (sup_beat)
                2'd0:    order.sup_black_tea <= in_data;
                2'd1:    order.sup_green_tea <= in_data;
                2'd2:    order.sup_milk      <= in_data;
                default: order.sup_pineapple <= in_data;
            endcase
        end
    end

endmodule

// ==== rtl/bev_recipe.sv ====
`timescale 1ns/1ps
`include "bev_macros.svh"

module bev_recipe (
    input  logic                 clk,
    input  bev_pkg::ctrl_state_e state,
    bev_order_if.consumer        order,
    bev_mem_if.recipe            mem,
    output bev_pkg::err_e        err
);
    bev_pkg::box_rec_t     rec;
    bev_pkg::box_rec_t     nrec;
    bev_pkg::box_rec_t     wr_rec;
    bev_pkg::recipe_t      q;
    logic [7:0]            qv;
    logic [`BEV_AMT_W-1:0] have [4];
    logic [`BEV_AMT_W-1:0] add [4];
    logic [2:0]            qs [4];
    logic [`BEV_AMT_W:0]   use_amt [4];
    logic [`BEV_AMT_W:0]   diff [4];
    logic [`BEV_AMT_W:0]   sum [4];
    logic [`BEV_AMT_W-1:0] fill [4];
    logic [3:0]            short_f;
    logic [3:0]            over_f;
    logic                  expired;

    always_ff @(posedge clk)
    begin
        if (mem.rd_done)
            rec <= mem.rd_data;
    end

    // record date earlier than the order date
    assign expired = (rec.month < {4'd0, order.date.month}) ||
                     (rec.month == {4'd0, order.date.month} && rec.day < {3'd0, order.date.day});

    // a quarter of the cup
    always_comb
    begin
        case (order.size)
            bev_pkg::L: qv = 8'(`BEV_CUP_L / 4);
            bev_pkg::M: qv = 8'(`BEV_CUP_M / 4);
            default:    qv = 8'(`BEV_CUP_S / 4);
        endcase
    end

    assign q = bev_pkg::recipe_q(order.drink);

    // per ingredient: black tea, green tea, milk, pineapple
    always_comb
    begin
        have = '{rec.black_tea, rec.green_tea, rec.milk, rec.pineapple};
        add  = '{order.sup_black_tea, order.sup_green_tea, order.sup_milk, order.sup_pineapple};
        qs   = '{q.black_tea, q.green_tea, q.milk, q.pineapple};
        for (int i = 0; i < 4; i++)
        begin
            use_amt[i] = {5'd0, qv} * {10'd0, qs[i]};
            diff[i]    = {1'b0, have[i]} - use_amt[i];
            sum[i]     = {1'b0, have[i]} + {1'b0, add[i]};
            short_f[i] = diff[i][`BEV_AMT_W];
            over_f[i]  = sum[i] > (`BEV_AMT_W + 1)'(`BEV_AMT_MAX);
            fill[i]    = over_f[i] ? `BEV_AMT_W'(`BEV_AMT_MAX) : sum[i][`BEV_AMT_W-1:0];
        end
    end

    always_comb
    begin
        nrec = rec;
        case (order.action)
            bev_pkg::MAKE_DRINK:
            begin
                if (expired)
                    err = bev_pkg::NO_EXP;
                else if (|short_f)
                    err = bev_pkg::NO_ING;
                else
                    err = bev_pkg::NO_ERR;
                nrec.black_tea = diff[0][`BEV_AMT_W-1:0];
                nrec.green_tea = diff[1][`BEV_AMT_W-1:0];
                nrec.milk      = diff[2][`BEV_AMT_W-1:0];
                nrec.pineapple = diff[3][`BEV_AMT_W-1:0];
            end
            bev_pkg::SUPPLY:
            begin
                err = (|over_f) ? bev_pkg::ING_OF : bev_pkg::NO_ERR;
                nrec.black_tea = fill[0];
                nrec.green_tea = fill[1];
                nrec.milk      = fill[2];
                nrec.pineapple = fill[3];
                nrec.month     = {4'd0, order.date.month};
                nrec.day       = {3'd0, order.date.day};
            end
            bev_pkg::CHECK_DATE: err = expired ? bev_pkg::NO_EXP : bev_pkg::NO_ERR;
            default:             err = bev_pkg::NO_ERR;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (state == bev_pkg::EVAL)
            wr_rec <= nrec;
    end

    assign mem.wr_data = wr_rec;
    // failed drinks and date checks leave the box untouched
    assign mem.wr_req  = (state == bev_pkg::REPORT) &&
                         (order.action == bev_pkg::SUPPLY ||
                          (order.action == bev_pkg::MAKE_DRINK && err == bev_pkg::NO_ERR));

endmodule

// ==== rtl/bev_dram_port.sv ====
`timescale 1ns/1ps
`include "bev_macros.svh"

module bev_dram_port (
    input  logic                   clk,
    input  logic                   inf,
    bev_order_if.consumer          order,
    bev_mem_if.port                mem,
    output logic [`BEV_ADDR_W-1:0] mem_addr,
    output logic                   mem_r_wb,
    output logic                   mem_in_valid,
    output logic [`BEV_REC_W-1:0]  mem_data_w,
    input  logic [`BEV_REC_W-1:0]  mem_data_r,
    input  logic                   mem_out_valid
);
    logic                   pending;
    logic                   wr_busy_q;
    logic [`BEV_ADDR_W-1:0] box_addr;

    // base plus eight bytes per box
    assign box_addr = `BEV_ADDR_W'(`BEV_MEM_BASE) + {6'd0, order.box_no, 3'b000};

    always_ff @(posedge clk or negedge inf)
    begin
        if (!inf)
        begin
            mem_in_valid <= 1'b0;
            mem_r_wb     <= 1'b0;
            pending      <= 1'b0;
            wr_busy_q    <= 1'b0;
        end
        else
        begin
            mem_in_valid <= mem.rd_req || mem.wr_req;
            if (mem.rd_req)
            begin
                mem_r_wb <= 1'b1;
                pending  <= 1'b1;
            end
            else if (mem.wr_req)
            begin
                mem_r_wb  <= 1'b0;
                pending   <= 1'b1;
                wr_busy_q <= 1'b1;
            end
            else if (mem_out_valid)
            begin
                pending   <= 1'b0;
                wr_busy_q <= 1'b0;
            end
        end
    end

    // address and data stay put until the bridge answers
    always_ff @(posedge clk)
    begin
        if (mem.rd_req || mem.wr_req)
            mem_addr <= box_addr;
        if (mem.wr_req)
            mem_data_w <= mem.wr_data;
    end

    assign mem.rd_done = mem_out_valid && pending && mem_r_wb;
    assign mem.rd_data = mem_data_r;
    assign mem.wr_busy = wr_busy_q;

    a_single_outstanding: assert property (@(posedge clk) disable iff (!inf)
        mem_in_valid |-> !$past(pending));

endmodule

// ==== rtl/bev_top.sv ====
`timescale 1ns/1ps
`include "bev_macros.svh"

module bev_top (
    input  logic                   clk,
    input  logic                   inf,
    input  logic                   sel_action_valid,
    input  logic                   type_valid,
    input  logic                   size_valid,
    input  logic                   date_valid,
    input  logic                   box_no_valid,
    input  logic                   box_sup_valid,
    input  logic [`BEV_AMT_W-1:0]  in_data,
    output logic [`BEV_ADDR_W-1:0] mem_addr,
    output logic                   mem_r_wb,
    output logic                   mem_in_valid,
    output logic [`BEV_REC_W-1:0]  mem_data_w,
    input  logic [`BEV_REC_W-1:0]  mem_data_r,
    input  logic                   mem_out_valid,
    output logic                   out_valid,
    output bev_pkg::err_e          err_msg,
    output logic                   complete
);
    bev_pkg::ctrl_state_e state;
    bev_pkg::err_e        err;
    logic [1:0]           sup_beat;

    bev_order_if order_if ();
    bev_mem_if   mem_if ();

    bev_ctrl u_ctrl (
        .clk, .inf,
        .sel_action_valid, .type_valid, .size_valid,
        .date_valid, .box_no_valid, .box_sup_valid,
        .action (order_if.action),
        .err,
        .mem    (mem_if.ctrl),
        .state, .sup_beat, .out_valid, .complete, .err_msg
    );

    bev_order_regs u_order_regs (
        .clk, .in_data,
        .sel_action_valid, .type_valid, .size_valid,
        .date_valid, .box_no_valid, .box_sup_valid,
        .state, .sup_beat,
        .order (order_if.source)
    );

    bev_recipe u_recipe (
        .clk, .state,
        .order (order_if.consumer),
        .mem   (mem_if.recipe),
        .err
    );

    bev_dram_port u_dram_port (
        .clk, .inf,
        .order (order_if.consumer),
        .mem   (mem_if.port),
        .mem_addr, .mem_r_wb, .mem_in_valid, .mem_data_w,
        .mem_data_r, .mem_out_valid
    );

endmodule

// ==== test/bev_tb.sv ====
`timescale 1ns/1ps
`include "bev_macros.svh"

module bev_tb;
    localparam int CLK_PERIOD = 10;
    localparam int NUM_TESTS  = 40;
    localparam int DIRECTED   = 9;

    logic                   clk;
    logic                   inf;
    logic                   sel_action_valid;
    logic                   type_valid;
    logic                   size_valid;
    logic                   date_valid;
    logic                   box_no_valid;
    logic                   box_sup_valid;
    logic [`BEV_AMT_W-1:0]  in_data;
    logic [`BEV_ADDR_W-1:0] mem_addr;
    logic                   mem_r_wb;
    logic                   mem_in_valid;
    logic [`BEV_REC_W-1:0]  mem_data_w;
    logic [`BEV_REC_W-1:0]  mem_data_r;
    logic                   mem_out_valid;
    logic                   out_valid;
    bev_pkg::err_e          err_msg;
    logic                   complete;

    bev_pkg::box_rec_t      mirror [256];
    bev_pkg::box_rec_t      ref_box [256];
    // address and record of each write-back still to come
    logic [`BEV_ADDR_W+`BEV_REC_W-1:0] exp_writes [$];
    logic [`BEV_ADDR_W-1:0] exp_rd_addr;
    logic [15:0]            lfsr;
    logic                   outstanding;

    bev_top u_bev_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp)
        else fail_now($sformatf("ERROR at %0d ns: %s expected %0h, got %0h",
                                $time, name, exp, act));
    endtask

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // quarters of the cup for black tea, green tea, milk and pineapple
    function automatic logic [11:0] quarters(input bev_pkg::drink_e d);
        case (d)
            bev_pkg::BLACK_TEA:           return {3'd4, 3'd0, 3'd0, 3'd0};
            bev_pkg::MILK_TEA:            return {3'd3, 3'd0, 3'd1, 3'd0};
            bev_pkg::EXTRA_MILK_TEA:      return {3'd2, 3'd0, 3'd2, 3'd0};
            bev_pkg::GREEN_TEA:           return {3'd0, 3'd4, 3'd0, 3'd0};
            bev_pkg::GREEN_MILK_TEA:      return {3'd0, 3'd2, 3'd2, 3'd0};
            bev_pkg::PINEAPPLE_JUICE:     return {3'd0, 3'd0, 3'd0, 3'd4};
            bev_pkg::SUPER_PINEAPPLE_TEA: return {3'd2, 3'd0, 3'd0, 3'd2};
            default:                      return {3'd2, 3'd0, 3'd1, 3'd1};
        endcase
    endfunction

    function automatic int quarter_ml(input bev_pkg::size_e s);
        case (s)
            bev_pkg::L: return `BEV_CUP_L / 4;
            bev_pkg::M: return `BEV_CUP_M / 4;
            default:    return `BEV_CUP_S / 4;
        endcase
    endfunction

    // initial memory contents spread over the box number
    function automatic bev_pkg::box_rec_t fill_rec(input int box);
        bev_pkg::box_rec_t r;
        r.black_tea = 12'(box * 37 + 300);
        r.green_tea = 12'(box * 53 + 200);
        r.month     = 8'(box % 12 + 1);
        r.milk      = 12'(box * 29 + 150);
        r.pineapple = 12'(box * 41 + 100);
        r.day       = 8'(box % 28 + 1);
        return r;
    endfunction

    task automatic preset(input logic [7:0] box, input int amt, input int month, input int day);
        mirror[box]  = '{12'(amt), 12'(amt), 8'(month), 12'(amt), 12'(amt), 8'(day)};
        ref_box[box] = mirror[box];
    endtask

    // reference model for one order
    task automatic predict(input bev_pkg::action_e act, input bev_pkg::drink_e drink,
                           input bev_pkg::size_e size, input logic [3:0] month,
                           input logic [4:0] day, input logic [47:0] sup,
                           input bev_pkg::box_rec_t rec, output bev_pkg::err_e err,
                           output bev_pkg::box_rec_t nrec, output logic wr);
        int          have [4];
        int          val [4];
        logic [11:0] q;
        logic        expired;
        logic        short_f;
        logic        over_f;
        have[0] = int'(rec.black_tea);
        have[1] = int'(rec.green_tea);
        have[2] = int'(rec.milk);
        have[3] = int'(rec.pineapple);
        q = quarters(drink);
        // record date before the order date
        expired = (int'(rec.month) * 256 + int'(rec.day)) < (int'(month) * 256 + int'(day));
        short_f = 1'b0;
        over_f  = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            if (act == bev_pkg::SUPPLY)
                val[i] = have[i] + int'(sup[47-12*i -: 12]);
            else
                val[i] = have[i] - int'(q[11-3*i -: 3]) * quarter_ml(size);
            short_f = short_f | (val[i] < 0);
            over_f  = over_f | (val[i] > `BEV_AMT_MAX);
            if (val[i] > `BEV_AMT_MAX)
                val[i] = `BEV_AMT_MAX;
        end
        nrec = rec;
        nrec.black_tea = 12'(val[0]);
        nrec.green_tea = 12'(val[1]);
        nrec.milk      = 12'(val[2]);
        nrec.pineapple = 12'(val[3]);
        case (act)
            bev_pkg::MAKE_DRINK:
            begin
                err = expired ? bev_pkg::NO_EXP : (short_f ? bev_pkg::NO_ING : bev_pkg::NO_ERR);
                wr  = (err == bev_pkg::NO_ERR);
            end
            bev_pkg::SUPPLY:
            begin
                err = over_f ? bev_pkg::ING_OF : bev_pkg::NO_ERR;
                nrec.month = {4'd0, month};
                nrec.day   = {3'd0, day};
                wr  = 1'b1;
            end
            default:
            begin
                err = expired ? bev_pkg::NO_EXP : bev_pkg::NO_ERR;
                wr  = 1'b0;
            end
        endcase
    endtask

    // one field on the input bus with an occasional idle cycle after it
    task automatic strobe(input int which, input logic [11:0] data);
        in_data = data;
        case (which)
            0:       sel_action_valid = 1'b1;
            1:       type_valid = 1'b1;
            2:       size_valid = 1'b1;
            3:       date_valid = 1'b1;
            4:       box_no_valid = 1'b1;
            default: box_sup_valid = 1'b1;
        endcase
        @(posedge clk);
        #1;
        {sel_action_valid, type_valid, size_valid, date_valid, box_no_valid, box_sup_valid} = '0;
        if (rand_bits(2) == 0)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_order(input bev_pkg::action_e act, input bev_pkg::drink_e drink,
                             input bev_pkg::size_e size, input logic [3:0] month,
                             input logic [4:0] day, input logic [7:0] box,
                             input logic [47:0] sup);
        bev_pkg::err_e          exp_err;
        bev_pkg::box_rec_t      nrec;
        logic                   wr;
        logic [`BEV_ADDR_W-1:0] addr;
        int                     n;
        addr = `BEV_ADDR_W'(`BEV_MEM_BASE + 8 * box);
        predict(act, drink, size, month, day, sup, ref_box[box], exp_err, nrec, wr);
        exp_rd_addr = addr;
        strobe(0, 12'(act));
        if (act == bev_pkg::MAKE_DRINK)
        begin
            strobe(1, 12'(drink));
            strobe(2, 12'(size));
        end
        strobe(3, {3'd0, month, day});
        strobe(4, {4'd0, box});
        if (act == bev_pkg::SUPPLY)
        begin
            for (int i = 0; i < 4; i++)
                strobe(5, sup[47-12*i -: 12]);
        end
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!out_valid && n < 100);
        if (!out_valid)
            fail_now("out_valid did not arrive within 100 cycles of the last input");
        check_value("err_msg", 64'(exp_err), 64'(err_msg));
        check_value("complete", 64'(exp_err == bev_pkg::NO_ERR), 64'(complete));
        if (wr)
        begin
            ref_box[box] = nrec;
            exp_writes.push_back({addr, nrec});
        end
        @(posedge clk);
        #1;
    endtask

    // one bridge request in flight
    always @(posedge clk or negedge inf)
    begin
        if (!inf)
            outstanding <= 1'b0;
        else if (mem_in_valid)
            outstanding <= 1'b1;
        else if (mem_out_valid)
            outstanding <= 1'b0;
    end

    a_in_valid_pulse: assert property (@(posedge clk) disable iff (!inf)
        mem_in_valid |=> !mem_in_valid)
        else fail_now("mem_in_valid stayed high for more than one cycle");

    a_one_request: assert property (@(posedge clk) disable iff (!inf)
        mem_in_valid |-> !outstanding)
        else fail_now("a second bridge request was issued before mem_out_valid");

    a_request_held: assert property (@(posedge clk) disable iff (!inf)
        outstanding && !mem_out_valid |=>
            $stable(mem_addr) && $stable(mem_r_wb) && $stable(mem_data_w))
        else fail_now("the bridge request changed before it completed");

    // memory model answering after 1 to 8 cycles
    initial
    begin : mem_model
        logic [`BEV_ADDR_W-1:0]            addr;
        logic                              r_wb;
        logic [`BEV_REC_W-1:0]             wdata;
        logic [`BEV_ADDR_W+`BEV_REC_W-1:0] exp;
        logic [7:0]                        slot;
        forever
        begin
            @(negedge clk);
            if (mem_in_valid)
            begin
                addr  = mem_addr;
                r_wb  = mem_r_wb;
                wdata = mem_data_w;
                slot  = 8'((addr - `BEV_ADDR_W'(`BEV_MEM_BASE)) >> 3);
                if (r_wb)
                begin
                    check_value("mem_addr", 64'(exp_rd_addr), 64'(addr));
                    assert (exp_writes.size() == 0)
                    else fail_now("a read was issued while an expected write-back was missing");
                end
                else
                begin
                    assert (exp_writes.size() != 0)
                    else fail_now("a write-back was issued where none was expected");
                    exp = exp_writes.pop_front();
                    check_value("mem_addr", 64'(exp[80:64]), 64'(addr));
                    check_value("mem_data_w", exp[63:0], wdata);
                end
                repeat (rand_bits(3) + 1) @(posedge clk);
                #1;
                if (!r_wb)
                    mirror[slot] = wdata;
                mem_data_r    = mirror[slot];
                mem_out_valid = 1'b1;
                @(posedge clk);
                #1;
                mem_out_valid = 1'b0;
            end
        end
    end

    initial
    begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        fail_now("the watchdog expired before the tests finished");
    end

    initial
    begin : main
        bev_pkg::action_e act;
        bev_pkg::drink_e  drink;
        bev_pkg::size_e   size;
        logic [3:0]       month;
        logic [4:0]       day;
        logic [7:0]       box;
        logic [47:0]      sup;
        int               n;
        clk = 1'b0;
        inf = 1'b0;
        {sel_action_valid, type_valid, size_valid, date_valid, box_no_valid, box_sup_valid} = '0;
        in_data       = '0;
        mem_data_r    = '0;
        mem_out_valid = 1'b0;
        lfsr          = 16'd19;
        for (int b = 0; b < 256; b++)
        begin
            mirror[b]  = fill_rec(b);
            ref_box[b] = mirror[b];
        end
        // full, expired, nearly empty and nearly full boxes
        preset(8'd1, 4000, 12, 31);
        preset(8'd2, 4000, 1, 1);
        preset(8'd3, 100, 12, 31);
        preset(8'd4, 4000, 12, 31);
        repeat (2) @(posedge clk);
        #1;
        inf = 1'b1;
        @(negedge clk);
        check_value("out_valid", 64'd0, 64'(out_valid));
        check_value("complete", 64'd0, 64'(complete));
        check_value("mem_in_valid", 64'd0, 64'(mem_in_valid));
        check_value("mem_r_wb", 64'd0, 64'(mem_r_wb));
        check_value("err_msg", 64'(bev_pkg::NO_ERR), 64'(err_msg));
        @(posedge clk);
        #1;
        run_order(bev_pkg::MAKE_DRINK, bev_pkg::BLACK_TEA, bev_pkg::L, 4'd6, 5'd15, 8'd1, 48'd0);
        run_order(bev_pkg::MAKE_DRINK, bev_pkg::SUPER_PINEAPPLE_MILK_TEA, bev_pkg::M,
                  4'd6, 5'd15, 8'd1, 48'd0);
        run_order(bev_pkg::MAKE_DRINK, bev_pkg::GREEN_MILK_TEA, bev_pkg::S,
                  4'd6, 5'd15, 8'd1, 48'd0);
        run_order(bev_pkg::MAKE_DRINK, bev_pkg::MILK_TEA, bev_pkg::L, 4'd6, 5'd15, 8'd2, 48'd0);
        run_order(bev_pkg::MAKE_DRINK, bev_pkg::PINEAPPLE_JUICE, bev_pkg::S,
                  4'd6, 5'd15, 8'd3, 48'd0);
        run_order(bev_pkg::SUPPLY, bev_pkg::BLACK_TEA, bev_pkg::L, 4'd7, 5'd4, 8'd3,
                  {12'd100, 12'd200, 12'd300, 12'd400});
        run_order(bev_pkg::SUPPLY, bev_pkg::BLACK_TEA, bev_pkg::L, 4'd7, 5'd4, 8'd4,
                  {12'd200, 12'd0, 12'd0, 12'd0});
        run_order(bev_pkg::CHECK_DATE, bev_pkg::BLACK_TEA, bev_pkg::L, 4'd6, 5'd15, 8'd2, 48'd0);
        run_order(bev_pkg::CHECK_DATE, bev_pkg::BLACK_TEA, bev_pkg::L, 4'd6, 5'd15, 8'd1, 48'd0);
        // random orders over a few boxes so that reads often follow write-backs
        for (int t = DIRECTED; t < NUM_TESTS; t++)
        begin
            act   = bev_pkg::action_e'(rand_bits(2) % 3);
            drink = bev_pkg::drink_e'(rand_bits(3));
            size  = bev_pkg::size_e'(rand_bits(2) % 3);
            month = 4'(rand_bits(4) % 12 + 1);
            day   = 5'(rand_bits(5) % 28 + 1);
            box   = 8'(rand_bits(3));
            sup   = {12'(rand_bits(10)), 12'(rand_bits(10)), 12'(rand_bits(10)),
                     12'(rand_bits(10))};
            run_order(act, drink, size, month, day, box, sup);
        end
        // give the last write-back, or a stray one, time to reach the memory
        n = 0;
        while ((n < 2 || outstanding || exp_writes.size() != 0) && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (exp_writes.size() != 0)
            fail_now("an expected write-back never reached the memory");
        else
        begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/bev_pkg.sv
rtl/bev_if.sv
rtl/bev_ctrl.sv
rtl/bev_order_regs.sv
rtl/bev_recipe.sv
rtl/bev_dram_port.sv
rtl/bev_top.sv
test/bev_tb.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = bev_tb
FILE_LIST = compile.f

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
